/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_trap_top
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'SIMULATION PASSED'

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
+incdir+verilog
verilog/trap_pkg.sv
verilog/trap_ctrl.sv
verilog/mcsr_file.sv
verilog/trap_top.sv
testbench/tb_trap_top.sv

/* testbench/tb_trap_top.sv */
// testbench for the trap unit, drives system ops and csr writes, checks stall, redirect, csr reads
`include "trap_settings.svh"

module tb_trap_top
    import trap_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD      = 40;
    localparam int RST_CYCLES  = 5;
    localparam int N_OPS       = 40;  // 5 rounds of 8 ops
    localparam int WATCHDOG_NS = (N_OPS * 12 + RST_CYCLES) * PERIOD;  // 12 cycles per op

    logic      clk       = 1'b0;
    logic      rst_n     = 1'b0;
    sys_op_t   sys_op    = '0;
    csr_wr_t   sw_wr     = '0;
    csr_addr_t csr_raddr = `CSR_MSTATUS;
    xlen_t     csr_rdata;
    redirect_t redirect;
    logic      stall;

    logic        chk_on         = 1'b0;  // off for the first reset edge
    logic        exp_stall      = 1'b0;
    logic        exp_redir      = 1'b0;
    xlen_t       exp_redir_addr = '0;
    xlen_t       exp_rdata      = '0;
    xlen_t       model [csr_addr_t];     // expected csr contents
    csr_addr_t   probe [5] = '{`CSR_MSTATUS, `CSR_MEPC, `CSR_MCAUSE, `CSR_MTVEC, 12'h344};
    logic [31:0] lcg_state = 32'hc418_333d;
    int          n_errors  = 0;
    int          n_checks  = 0;

    trap_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sys_op_i    (sys_op),
        .sw_wr_i     (sw_wr),
        .csr_raddr_i (csr_raddr),
        .csr_rdata_o (csr_rdata),
        .redirect_o  (redirect),
        .stall_o     (stall)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic xlen_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void flag_error(string what, xlen_t got, xlen_t want);
        n_errors++;
        $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
    endfunction

    // model updates made before a step show up in the cycle after its edge
    task automatic step(input logic stall_e, input logic redir_e, input csr_addr_t raddr);
        @(posedge clk);
        #2;
        exp_stall = stall_e;
        exp_redir = redir_e;
        csr_raddr = raddr;
        exp_rdata = model.exists(raddr) ? model[raddr] : '0;  // unmapped reads zero
    endtask

    task automatic sw_write(input csr_addr_t addr, input xlen_t data);
        step(1'b0, 1'b0, addr);  // old value still visible
        sw_wr = '{we: 1'b1, addr: addr, data: data};
        model[addr] = (addr == `CSR_MEPC || addr == `CSR_MTVEC) ? data & ~32'h3 : data;
        step(1'b0, 1'b0, addr);
        sw_wr.we = 1'b0;
    endtask

    // ecall or ebreak, a busy atomic drops it
    task automatic take_trap(input logic is_ecall, input logic with_jump, input logic busy);
        xlen_t pc_val;
        xlen_t target;
        xlen_t st;
        logic  ok;
        pc_val = lcg_next() & ~32'h3;
        target = lcg_next() & ~32'h3;
        ok     = !busy;
        st     = model[`CSR_MSTATUS];
        step(1'b0, 1'b0, `CSR_MEPC);
        sys_op = '{valid: 1'b1, ecall: is_ecall, ebreak: !is_ecall, mret: 1'b0, pc: pc_val,
                   jump: with_jump, jump_addr: target, atom_busy: busy};
        step(ok, 1'b0, `CSR_MEPC);  // edge A
        sys_op = '0;
        step(ok, 1'b0, `CSR_MEPC);  // mepc write still in flight
        if (ok) model[`CSR_MEPC] = with_jump ? target - 32'd4 : pc_val;
        step(ok, 1'b0, `CSR_MEPC);  // mepc after A+2
        st[`MSTATUS_MPIE] = st[`MSTATUS_MIE];
        st[`MSTATUS_MIE]  = 1'b0;
        if (ok) model[`CSR_MSTATUS] = st;
        step(ok, 1'b0, `CSR_MSTATUS);  // mstatus after A+3
        if (ok) model[`CSR_MCAUSE] = is_ecall ? `CAUSE_ECALL_M : `CAUSE_BREAKPOINT;
        exp_redir_addr = model[`CSR_MTVEC];
        step(1'b0, ok, `CSR_MCAUSE);  // stall gone, redirect strobe
        step(1'b0, 1'b0, `CSR_MSTATUS);
    endtask

    task automatic do_mret();
        xlen_t st;
        st = model[`CSR_MSTATUS];
        step(1'b0, 1'b0, `CSR_MSTATUS);
        sys_op.valid = 1'b1;
        sys_op.mret  = 1'b1;
        step(1'b1, 1'b0, `CSR_MSTATUS);  // edge A
        sys_op = '0;
        step(1'b1, 1'b0, `CSR_MSTATUS);  // mstatus write still in flight
        st[`MSTATUS_MIE]  = st[`MSTATUS_MPIE];
        st[`MSTATUS_MPIE] = 1'b1;
        model[`CSR_MSTATUS] = st;
        exp_redir_addr = model[`CSR_MEPC];
        step(1'b0, 1'b1, `CSR_MSTATUS);  // write and redirect after A+2
        step(1'b0, 1'b0, `CSR_MEPC);
    endtask

    initial begin
        model[`CSR_MSTATUS] = '0;
        model[`CSR_MEPC]    = '0;
        model[`CSR_MCAUSE]  = '0;
        model[`CSR_MTVEC]   = '0;
        for (int k = 0; k < RST_CYCLES; k++) begin
            step(1'b0, 1'b0, probe[k % 5]);  // quiet outputs, csrs read zero
            chk_on = 1'b1;
        end
        rst_n = 1'b1;
        step(1'b0, 1'b0, `CSR_MTVEC);
        for (int r = 0; r < N_OPS / 8; r++) begin
            sw_write(`CSR_MTVEC, lcg_next() & ~32'h3);
            sw_write(`CSR_MSTATUS, lcg_next());  // random mie/mpie seed
            take_trap(1'b1, r[0], 1'b0);
            do_mret();
            sw_write(`CSR_MSTATUS, lcg_next());
            take_trap(1'b0, 1'b1, 1'b0);
            do_mret();
            take_trap(1'b1, 1'b0, 1'b1);  // atomic busy
        end
        step(1'b0, 1'b0, `CSR_MCAUSE);
        $display("errors %0d, checks %0d", n_errors, n_checks);
        if (n_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, test sequence still running after %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    a_ctl: assert property (@(posedge clk) disable iff (!chk_on)
        {stall, redirect.valid} == {exp_stall, exp_redir}) n_checks++;
    else flag_error("{stall, redirect valid}",
                    xlen_t'({$sampled(stall), $sampled(redirect.valid)}),
                    xlen_t'({exp_stall, exp_redir}));

    a_redir_addr: assert property (@(posedge clk) disable iff (!chk_on)
        !redirect.valid || (redirect.addr == exp_redir_addr)) n_checks++;
    else flag_error("redirect addr", $sampled(redirect.addr), exp_redir_addr);

    a_rdata: assert property (@(posedge clk) disable iff (!chk_on)
        csr_rdata == exp_rdata) n_checks++;
    else flag_error($sformatf("csr %h", $sampled(csr_raddr)), $sampled(csr_rdata), exp_rdata);

endmodule

/* verilog/mcsr_file.sv */
// machine csr file with mtvec, mepc, mcause, mstatus, two write ports and a read port
`include "trap_settings.svh"

module mcsr_file
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  csr_wr_t   trap_wr_i,  // from the trap sequencer, priority
    input  csr_wr_t   sw_wr_i,    // from csr instructions / testbench

    input  csr_addr_t raddr_i,
    output xlen_t     rdata_o,    // combinational read

    output xlen_t     mstatus_o,  // direct taps for the sequencer
    output xlen_t     mepc_o,
    output xlen_t     mtvec_o
);

    xlen_t   mstatus_q;
    xlen_t   mepc_q;
    xlen_t   mcause_q;
    xlen_t   mtvec_q;

    csr_wr_t wr;          // selected write
    xlen_t   wr_aligned;  // data with low bits cleared

    // trap write wins, a colliding software write is lost
    assign wr = trap_wr_i.we ? trap_wr_i : sw_wr_i;

    // direct mode vector and return address are word aligned
    assign wr_aligned = {wr.data[`TRAP_XLEN-1:`CSR_ALIGN_BITS], {`CSR_ALIGN_BITS{1'b0}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mtvec_q   <= '0;
        end else if (wr.we) begin
            case (wr.addr)
                `CSR_MSTATUS: mstatus_q <= wr.data;
                `CSR_MEPC:    mepc_q    <= wr_aligned;
                `CSR_MCAUSE:  mcause_q  <= wr.data;
                `CSR_MTVEC:   mtvec_q   <= wr_aligned;
                default: ;  // unmapped, ignored
            endcase
        end
    end

    // read mux
    always_comb begin
        case (raddr_i)
            `CSR_MSTATUS: rdata_o = mstatus_q;
            `CSR_MEPC:    rdata_o = mepc_q;
            `CSR_MCAUSE:  rdata_o = mcause_q;
            `CSR_MTVEC:   rdata_o = mtvec_q;
            default:      rdata_o = '0;  // unmapped reads zero
        endcase
    end

    assign mstatus_o = mstatus_q;
    assign mepc_o    = mepc_q;
    assign mtvec_o   = mtvec_q;

    // sequencer only ever touches the three trap csrs
    a_trap_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
        trap_wr_i.we |-> (trap_wr_i.addr inside {`CSR_MEPC, `CSR_MSTATUS, `CSR_MCAUSE}));

endmodule

/* verilog/trap_ctrl.sv */
// trap sequencer, takes ecall/ebreak/mret events, stalls the core and writes the machine csrs
`include "trap_settings.svh"

module trap_ctrl
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  sys_op_t   sys_op_i,    // event from the core

    input  xlen_t     mstatus_i,   // current csr values
    input  xlen_t     mepc_i,
    input  xlen_t     mtvec_i,

    output csr_wr_t   csr_wr_o,    // to csr file, wins over software writes
    output redirect_t redirect_o,  // fetch redirect strobe
    output logic      stall_o      // hold the pipeline
);

    trap_state_e state_q;
    trap_state_e state_d;

    logic      seq_idle;      // no state and no write in flight
    logic      accept_trap;
    logic      accept_mret;

    xlen_t     epc_q;         // captured return address
    xlen_t     cause_q;       // captured exception code

    xlen_t     mstatus_trap;  // mstatus after trap entry
    xlen_t     mstatus_mret;  // mstatus after mret

    logic      wr_we_q;
    logic      wr_last_q;     // write in flight ends the sequence
    csr_addr_t wr_addr_q;
    xlen_t     wr_data_q;

    logic      redir_valid_q;
    xlen_t     redir_addr_q;

    // the write register trails the state by one cycle, so the last
    // write keeps the stall up until the redirect cycle
    assign seq_idle = (state_q == st_idle) && !wr_we_q;
    assign stall_o  = (state_q != st_idle) || wr_we_q;

    // ecall/ebreak wait out atomics; mret goes regardless
    assign accept_trap = seq_idle && sys_op_i.valid && (sys_op_i.ecall || sys_op_i.ebreak)
                         && !sys_op_i.atom_busy;
    assign accept_mret = seq_idle && sys_op_i.valid && sys_op_i.mret;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept_trap) begin
                    state_d = st_wr_mepc;  // traps take priority
                end else if (accept_mret) begin
                    state_d = st_mret_mstatus;
                end
            end
            st_wr_mepc:      state_d = st_wr_mstatus;
            st_wr_mstatus:   state_d = st_wr_mcause;
            st_wr_mcause:    state_d = st_idle;
            st_mret_mstatus: state_d = st_idle;
            default:         state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // event payload, held for the write sequence
    always_ff @(posedge clk) begin
        if (accept_trap) begin
            // ecall wins if both flags are set
            cause_q <= sys_op_i.ecall ? xlen_t'(`CAUSE_ECALL_M) : xlen_t'(`CAUSE_BREAKPOINT);
            if (sys_op_i.jump) begin
                epc_q <= sys_op_i.jump_addr - xlen_t'(4);  // undo the jump offset
            end else begin
                epc_q <= sys_op_i.pc;
            end
        end
    end

    // mstatus rewrite for both directions
    always_comb begin
        mstatus_trap                = mstatus_i;
        mstatus_trap[`MSTATUS_MPIE] = mstatus_i[`MSTATUS_MIE];  // save mie
        mstatus_trap[`MSTATUS_MIE]  = 1'b0;                     // interrupts off in handler

        mstatus_mret                = mstatus_i;
        mstatus_mret[`MSTATUS_MIE]  = mstatus_i[`MSTATUS_MPIE];  // restore
        mstatus_mret[`MSTATUS_MPIE] = 1'b1;
    end

    // write strobe, one per non-idle state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_we_q   <= 1'b0;
            wr_last_q <= 1'b0;
        end else begin
            wr_we_q   <= (state_q != st_idle);
            wr_last_q <= (state_q == st_wr_mcause) || (state_q == st_mret_mstatus);
        end
    end

    // write address and data
    always_ff @(posedge clk) begin
        case (state_q)
            st_wr_mepc: begin
                wr_addr_q <= `CSR_MEPC;
                wr_data_q <= epc_q;
            end
            st_wr_mstatus: begin
                wr_addr_q <= `CSR_MSTATUS;
                wr_data_q <= mstatus_trap;  // mepc already written, mstatus still old
            end
            st_wr_mcause: begin
                wr_addr_q <= `CSR_MCAUSE;
                wr_data_q <= cause_q;
            end
            st_mret_mstatus: begin
                wr_addr_q <= `CSR_MSTATUS;
                wr_data_q <= mstatus_mret;
            end
            default: ;  // hold, we is low
        endcase
    end

    assign csr_wr_o.we   = wr_we_q;
    assign csr_wr_o.addr = wr_addr_q;
    assign csr_wr_o.data = wr_data_q;

    // redirect follows the last write by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redir_valid_q <= 1'b0;
        end else begin
            redir_valid_q <= wr_we_q && wr_last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_we_q && wr_last_q) begin
            // mcause ends a trap, mstatus ends an mret
            redir_addr_q <= (wr_addr_q == `CSR_MCAUSE) ? mtvec_i : mepc_i;
        end
    end

    assign redirect_o.valid = redir_valid_q;
    assign redirect_o.addr  = redir_addr_q;

    // one event kind at a time
    a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
        sys_op_i.valid |-> $onehot0({sys_op_i.ecall, sys_op_i.ebreak, sys_op_i.mret}));

    // core must hold events back while stalled
    a_no_op_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_o |-> !sys_op_i.valid);

    // redirect is a strobe
    a_redir_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o.valid |=> !redirect_o.valid);

endmodule

/* verilog/trap_pkg.sv */
// trap sequencer package with the word types, core event and csr bus structs, fsm states
`include "trap_settings.svh"

package trap_pkg;

    // one register-width word, addresses and csr data
    typedef logic [`TRAP_XLEN-1:0] xlen_t;

    // csr address as encoded in the instruction
    typedef logic [11:0] csr_addr_t;

    // system-op event from the core, one-cycle strobe
    typedef struct packed {
        logic  valid;      // event qualifier
        logic  ecall;
        logic  ebreak;
        logic  mret;
        xlen_t pc;         // address of the system instruction
        logic  jump;       // a jump is in flight in ex
        xlen_t jump_addr;  // its target
        logic  atom_busy;  // atomic op still running, trap must wait
    } sys_op_t;

    // csr write request
    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    // fetch redirect, valid is a single-cycle strobe
    typedef struct packed {
        logic  valid;
        xlen_t addr;
    } redirect_t;

    // trap sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_wr_mepc,
        st_wr_mstatus,
        st_wr_mcause,
        st_mret_mstatus
    } trap_state_e;

endpackage

/* verilog/trap_settings.svh */
// trap sequencer settings with widths, machine csr addresses, cause codes and mstatus bits
`ifndef TRAP_SETTINGS_SVH
`define TRAP_SETTINGS_SVH

// register and address width, single hart rv32
`define TRAP_XLEN 32

// machine-mode csr addresses
`define CSR_MSTATUS 12'h300  // global interrupt enables
`define CSR_MTVEC   12'h305  // trap vector base, direct mode only
`define CSR_MEPC    12'h341  // return address of the trapping instruction
`define CSR_MCAUSE  12'h342  // exception code of the last trap

// synchronous exception codes written to mcause
// interrupt bit stays zero, no async sources here
`define CAUSE_ECALL_M    11  // environment call from m-mode
`define CAUSE_BREAKPOINT 3   // ebreak

// mstatus bit positions
`define MSTATUS_MIE  3  // machine interrupt enable
`define MSTATUS_MPIE 7  // previous mie, saved on trap entry

// mtvec and mepc keep word alignment
`define CSR_ALIGN_BITS 2

`endif

/* verilog/trap_top.sv */
// trap unit top, joins the trap sequencer and the machine csr file
module trap_top
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  sys_op_t   sys_op_i,     // core events
    input  csr_wr_t   sw_wr_i,      // software csr write

    input  csr_addr_t csr_raddr_i,
    output xlen_t     csr_rdata_o,

    output redirect_t redirect_o,   // to fetch
    output logic      stall_o       // to pipeline control
);

    csr_wr_t trap_wr;  // sequencer write into the csr file
    xlen_t   mstatus;
    xlen_t   mepc;
    xlen_t   mtvec;

    trap_ctrl trap_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sys_op_i   (sys_op_i),
        .mstatus_i  (mstatus),
        .mepc_i     (mepc),
        .mtvec_i    (mtvec),
        .csr_wr_o   (trap_wr),
        .redirect_o (redirect_o),
        .stall_o    (stall_o)
    );

    mcsr_file mcsr_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .trap_wr_i (trap_wr),
        .sw_wr_i   (sw_wr_i),
        .raddr_i   (csr_raddr_i),
        .rdata_o   (csr_rdata_o),
        .mstatus_o (mstatus),
        .mepc_o    (mepc),
        .mtvec_o   (mtvec)
    );

    // a software write during a trap sequence would be lost or race the sequencer
    a_no_sw_wr_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        sw_wr_i.we |-> !stall_o);

endmodule
